//--- flist.f
+incdir+sim
verilog/decode_pkg.sv
verilog/decode_ctrl_if.sv
verilog/if_id_reg.sv
verilog/inst_decoder.sv
verilog/branch_unit.sv
verilog/stall_check.sv
verilog/operand_mux.sv
verilog/decode_stage.sv
sim/tb_clock.sv
sim/tb_decode.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv sim/*.sv sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected decode of one instruction, built from the ISA rules
typedef struct packed {
    decode_pkg::alu_op_t   alu;
    decode_pkg::word_t     op1;
    decode_pkg::word_t     op2;
    logic                  wen;
    decode_pkg::reg_addr_t wdest;
    logic                  load;
    logic                  store;
    logic                  jbr;
    logic                  taken;                   // before gating by id_over
    decode_pkg::word_t     target;
    logic                  rt_src;
} dec_exp_t;

function automatic dec_exp_t with_link(
    input dec_exp_t              e,
    input decode_pkg::word_t     pc,
    input decode_pkg::reg_addr_t dest
);
    e.alu.op_add = 1'b1;
    e.op1        = pc;
    e.op2        = decode_pkg::LINK_OFFSET;         // return address past the delay slot
    e.wen        = 1'b1;
    e.wdest      = dest;
    return e;
endfunction

function automatic dec_exp_t model_decode(
    input decode_pkg::word_t inst,
    input decode_pkg::word_t pc,
    input decode_pkg::word_t rsv,
    input decode_pkg::word_t rtv
);
    dec_exp_t          e;
    decode_pkg::word_t sext;
    decode_pkg::word_t zext;
    decode_pkg::word_t slot;
    logic signed [31:0] srs;
    logic [5:0]         op;
    e        = '0;
    op       = inst[31:26];
    sext     = {{16{inst[15]}}, inst[15:0]};
    zext     = {16'd0, inst[15:0]};
    slot     = pc + 32'd4;
    srs      = rsv;
    e.op1    = rsv;
    e.op2    = rtv;
    e.rt_src = 1'b1;
    e.target = slot + (sext << 2);                  // branch target
    case (op)
        decode_pkg::OP_SPECIAL: begin
            e.wen   = 1'b1;
            e.wdest = inst[15:11];
            case (inst[5:0])
                decode_pkg::FN_ADDU: e.alu.op_add = 1'b1;
                decode_pkg::FN_SUBU: e.alu.op_sub = 1'b1;
                decode_pkg::FN_SLT:  e.alu.op_slt = 1'b1;
                decode_pkg::FN_SLTU: e.alu.op_sltu = 1'b1;
                decode_pkg::FN_AND:  e.alu.op_and = 1'b1;
                decode_pkg::FN_OR:   e.alu.op_or = 1'b1;
                decode_pkg::FN_XOR:  e.alu.op_xor = 1'b1;
                decode_pkg::FN_NOR:  e.alu.op_nor = 1'b1;
                decode_pkg::FN_SLL, decode_pkg::FN_SLLV: e.alu.op_sll = 1'b1;
                decode_pkg::FN_SRL, decode_pkg::FN_SRLV: e.alu.op_srl = 1'b1;
                decode_pkg::FN_SRA, decode_pkg::FN_SRAV: e.alu.op_sra = 1'b1;
                decode_pkg::FN_JR, decode_pkg::FN_JALR: begin
                    e.jbr    = 1'b1;
                    e.taken  = 1'b1;
                    e.target = rsv;
                    e.rt_src = 1'b0;
                    if (inst[5:0] == decode_pkg::FN_JALR) begin
                        e = with_link(e, pc, inst[15:11]);
                    end else begin
                        e.wen   = 1'b0;
                        e.wdest = '0;
                    end
                end
                default: begin
                    e.wen   = 1'b0;
                    e.wdest = '0;
                end
            endcase
            if (inst[5:0] inside {decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA})
                e.op1 = {27'd0, inst[10:6]};        // constant shift amount
        end
        decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI,
        decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LUI, decode_pkg::OP_LW: begin
            e.wen    = 1'b1;
            e.wdest  = inst[20:16];
            e.rt_src = 1'b0;
            e.load   = (op == decode_pkg::OP_LW);
            e.op2    = (op inside {decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
                                   decode_pkg::OP_XORI, decode_pkg::OP_LUI}) ? zext : sext;
            case (op)
                decode_pkg::OP_SLTI:  e.alu.op_slt = 1'b1;
                decode_pkg::OP_SLTIU: e.alu.op_sltu = 1'b1;
                decode_pkg::OP_ANDI:  e.alu.op_and = 1'b1;
                decode_pkg::OP_ORI:   e.alu.op_or = 1'b1;
                decode_pkg::OP_XORI:  e.alu.op_xor = 1'b1;
                decode_pkg::OP_LUI:   e.alu.op_lui = 1'b1;
                default:              e.alu.op_add = 1'b1;  // addiu and lw
            endcase
        end
        decode_pkg::OP_SW: begin
            e.alu.op_add = 1'b1;
            e.op2        = sext;
            e.store      = 1'b1;
        end
        decode_pkg::OP_BEQ, decode_pkg::OP_BNE: begin
            e.jbr   = 1'b1;
            e.taken = (op == decode_pkg::OP_BEQ) ? (rsv == rtv) : (rsv != rtv);
        end
        decode_pkg::OP_BLEZ, decode_pkg::OP_BGTZ, decode_pkg::OP_REGIMM: begin
            e.jbr    = 1'b1;
            e.rt_src = 1'b0;
            case (op)
                decode_pkg::OP_BLEZ: e.taken = (srs <= 0);
                decode_pkg::OP_BGTZ: e.taken = (srs > 0);
                default:             e.taken = inst[16] ? (srs >= 0) : (srs < 0);
            endcase
        end
        decode_pkg::OP_J, decode_pkg::OP_JAL: begin
            e.jbr    = 1'b1;
            e.taken  = 1'b1;
            e.rt_src = 1'b0;
            e.target = {slot[31:28], inst[25:0], 2'b00};
            if (op == decode_pkg::OP_JAL)
                e = with_link(e, pc, decode_pkg::LINK_REG);
        end
        default: ;                                  // no-op
    endcase
    return e;
endfunction

// a nonzero source that a later stage is about to write
function automatic logic reg_busy(
    input decode_pkg::reg_addr_t r,
    input decode_pkg::reg_addr_t d0,
    input decode_pkg::reg_addr_t d1,
    input decode_pkg::reg_addr_t d2
);
    return (r != '0) && (r == d0 || r == d1 || r == d2);
endfunction

`endif

//--- sim/tb_decode.sv
`timescale 1ns/1ps

module tb_decode;

    localparam int PERIOD = 40;
    localparam int NCYC   = 2000;
    localparam int LIMIT  = (NCYC + 12) * PERIOD + 2000;   // reset, test cycles, margin

    // R-type functs, three-register forms first, then constant shifts
    localparam logic [5:0] REG_FN [14] = '{
        decode_pkg::FN_ADDU, decode_pkg::FN_SUBU, decode_pkg::FN_SLT, decode_pkg::FN_SLTU,
        decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR, decode_pkg::FN_NOR,
        decode_pkg::FN_SLLV, decode_pkg::FN_SRLV, decode_pkg::FN_SRAV,
        decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA
    };
    localparam logic [5:0] IMM_OP [10] = '{
        decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI,
        decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LW, decode_pkg::OP_SW,
        decode_pkg::OP_BEQ, decode_pkg::OP_BNE
    };

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_valid;
    logic                  exe_allowin;
    decode_pkg::word_t     fetch_pc;
    decode_pkg::word_t     fetch_inst;
    decode_pkg::word_t     rs_value;
    decode_pkg::word_t     rt_value;
    decode_pkg::reg_addr_t exe_wdest;
    decode_pkg::reg_addr_t mem_wdest;
    decode_pkg::reg_addr_t wb_wdest;
    logic                  id_allowin;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    logic                  jbr_taken;
    decode_pkg::word_t     jbr_target;
    logic                  id_over;
    decode_pkg::alu_op_t   alu_op;
    decode_pkg::word_t     alu_operand1;
    decode_pkg::word_t     alu_operand2;
    logic                  mem_load;
    logic                  mem_store;
    decode_pkg::word_t     store_data;
    logic                  rf_wen;
    decode_pkg::reg_addr_t rf_wdest;
    decode_pkg::word_t     id_pc;

    integer            seed = 40267;
    logic              m_valid;                     // stage register model
    decode_pkg::word_t m_pc;
    decode_pkg::word_t m_inst;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clk(clk));

    decode_stage dut0 (.*);

    `include "decode_model.svh"

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic expected_over();
        dec_exp_t e;
        logic     busy;
        e    = model_decode(m_inst, m_pc, rs_value, rt_value);
        busy = reg_busy(m_inst[25:21], exe_wdest, mem_wdest, wb_wdest)
            || (e.rt_src && reg_busy(m_inst[20:16], exe_wdest, mem_wdest, wb_wdest));
        return m_valid && !busy && exe_allowin && (!e.jbr || fetch_valid);
    endfunction

    //**************************************************************************
    // compare against the model
    task automatic check_outputs;
        dec_exp_t e;
        logic     over;
        e    = model_decode(m_inst, m_pc, rs_value, rt_value);
        over = expected_over();
        check_eq(32'(id_over), 32'(over), "id_over");
        check_eq(32'(id_allowin), 32'(!m_valid || (over && exe_allowin)), "id_allowin");
        check_eq(32'(jbr_taken), 32'(e.taken && over), "jbr_taken");
        check_eq(32'(rs), 32'(m_inst[25:21]), "rs");
        check_eq(32'(rt), 32'(m_inst[20:16]), "rt");
        if (m_valid)
            check_eq(id_pc, m_pc, "id_pc");
        if (over) begin                             // ID to EXE bundle is live
            check_eq(32'(alu_op), 32'(e.alu), "alu_op");
            check_eq(alu_operand1, e.op1, "alu_operand1");
            check_eq(alu_operand2, e.op2, "alu_operand2");
            check_eq(32'(rf_wen), 32'(e.wen), "rf_wen");
            check_eq(32'(rf_wdest), 32'(e.wdest), "rf_wdest");
            check_eq(32'(mem_load), 32'(e.load), "mem_load");
            check_eq(32'(mem_store), 32'(e.store), "mem_store");
            check_eq(store_data, rt_value, "store_data");
            if (e.taken)
                check_eq(jbr_target, e.target, "jbr_target");
        end
    endtask

    function automatic decode_pkg::word_t random_inst();
        decode_pkg::word_t r;
        decode_pkg::word_t p;
        logic [4:0]        pick;
        r    = $random(seed);
        p    = $random(seed);
        pick = p[4:0];
        if (pick < 5'd11)
            return {decode_pkg::OP_SPECIAL, r[25:11], 5'd0, REG_FN[pick[3:0]]};
        if (pick < 5'd14)
            return {decode_pkg::OP_SPECIAL, 5'd0, r[20:6], REG_FN[pick[3:0]]};
        if (pick < 5'd24)
            return {IMM_OP[4'(pick - 5'd14)], r[25:0]};
        case (pick)
            5'd24:   return {decode_pkg::OP_LUI, 5'd0, r[20:0]};
            5'd25:   return {decode_pkg::OP_BLEZ, r[25:21], 5'd0, r[15:0]};
            5'd26:   return {decode_pkg::OP_BGTZ, r[25:21], 5'd0, r[15:0]};
            5'd27:   return {decode_pkg::OP_REGIMM, r[25:21], 4'd0, r[16:0]};  // bgez or bltz
            5'd28:   return {decode_pkg::OP_J, r[25:0]};
            5'd29:   return {decode_pkg::OP_JAL, r[25:0]};
            5'd30:   return {decode_pkg::OP_SPECIAL, r[25:21], 15'd0, decode_pkg::FN_JR};
            default: return {decode_pkg::OP_SPECIAL, r[25:21], 5'd0, r[15:11], 5'd0,
                             decode_pkg::FN_JALR};
        endcase
    endfunction

    task automatic drive_inputs;
        decode_pkg::word_t r;
        r           = $random(seed);
        fetch_valid = (r % 100) < 80;
        r           = $random(seed);
        exe_allowin = (r % 100) < 85;
        r           = $random(seed);
        fetch_pc    = {r[31:2], 2'b00};
        fetch_inst  = random_inst();
        rs_value    = $random(seed);
        rt_value    = $random(seed);
        r           = $random(seed);
        if (r[19:18] == 2'b00)
            rt_value = rs_value;                    // gives beq/bne both outcomes
        if (r[21:20] == 2'b00)
            rs_value = '0;
        exe_wdest   = r[0] ? r[5:1] : 5'd0;
        mem_wdest   = r[6] ? r[11:7] : 5'd0;
        wb_wdest    = r[12] ? r[17:13] : 5'd0;
    endtask

    // what the next rising edge does to the stage register
    task automatic advance_model;
        logic allow;
        allow = !m_valid || (expected_over() && exe_allowin);
        if (allow) begin
            m_valid = fetch_valid;
            if (fetch_valid) begin
                m_pc   = fetch_pc;
                m_inst = fetch_inst;
            end
        end
    endtask

    //**************************************************************************
    // main sequence
    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b1;                         // parks an unused opcode in the register
        fetch_pc    = '0;
        fetch_inst  = 32'hffff_ffff;
        exe_allowin = 1'b1;
        rs_value    = '0;
        rt_value    = '0;
        exe_wdest   = '0;
        mem_wdest   = '0;
        wb_wdest    = '0;
        m_valid     = 1'b0;
        m_pc        = '0;
        m_inst      = 32'hffff_ffff;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_eq(32'(id_over), 32'd0, "id_over after reset");
        check_eq(32'(jbr_taken), 32'd0, "jbr_taken after reset");
        check_eq(32'(rf_wen), 32'd0, "rf_wen after reset");
        check_eq(32'(mem_load), 32'd0, "mem_load after reset");
        check_eq(32'(mem_store), 32'd0, "mem_store after reset");
        check_eq(32'(id_allowin), 32'd1, "id_allowin after reset");
        for (int n = 0; n < NCYC; n++) begin
            drive_inputs();
            advance_model();
            @(negedge clk);
            check_outputs();
        end
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(LIMIT);
        $display("watchdog: the run did not finish within %0d ns", LIMIT);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 40                       // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  decode_pkg::word_t     fetch_pc,
    input  decode_pkg::word_t     fetch_inst,
    input  logic                  exe_allowin,
    input  decode_pkg::word_t     rs_value,
    input  decode_pkg::word_t     rt_value,
    input  decode_pkg::reg_addr_t exe_wdest,
    input  decode_pkg::reg_addr_t mem_wdest,
    input  decode_pkg::reg_addr_t wb_wdest,
    output logic                  id_allowin,
    output decode_pkg::reg_addr_t rs,               // register file read ports
    output decode_pkg::reg_addr_t rt,
    output logic                  jbr_taken,
    output decode_pkg::word_t     jbr_target,
    output logic                  id_over,
    output decode_pkg::alu_op_t   alu_op,
    output decode_pkg::word_t     alu_operand1,
    output decode_pkg::word_t     alu_operand2,
    output logic                  mem_load,
    output logic                  mem_store,
    output decode_pkg::word_t     store_data,
    output logic                  rf_wen,
    output decode_pkg::reg_addr_t rf_wdest,
    output decode_pkg::word_t     id_pc
);

    logic              id_valid;
    decode_pkg::word_t inst;

    decode_ctrl_if ctrl ();

    if_id_reg u_if_id_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .id_over     (id_over),
        .exe_allowin (exe_allowin),
        .id_valid    (id_valid),
        .id_allowin  (id_allowin),
        .pc          (id_pc),
        .inst        (inst)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .ctrl (ctrl.src)
    );

    branch_unit u_branch_unit (
        .pc         (id_pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .id_over    (id_over),
        .ctrl       (ctrl.dst),
        .jbr_taken  (jbr_taken),
        .jbr_target (jbr_target)
    );

    stall_check u_stall_check (
        .id_valid    (id_valid),
        .fetch_valid (fetch_valid),
        .exe_allowin (exe_allowin),
        .exe_wdest   (exe_wdest),
        .mem_wdest   (mem_wdest),
        .wb_wdest    (wb_wdest),
        .ctrl        (ctrl.dst),
        .id_over     (id_over)
    );

    operand_mux u_operand_mux (
        .pc           (id_pc),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .ctrl         (ctrl.dst),
        .alu_operand1 (alu_operand1),
        .alu_operand2 (alu_operand2),
        .rf_wen       (rf_wen),
        .rf_wdest     (rf_wdest),
        .mem_load     (mem_load),
        .mem_store    (mem_store),
        .alu_op       (alu_op)
    );

    assign rs         = ctrl.rs;
    assign rt         = ctrl.rt;
    assign store_data = rt_value;                   // sw writes rt unchanged

endmodule

//--- verilog/operand_mux.sv
`timescale 1ns/1ps

module operand_mux (
    input  decode_pkg::word_t      pc,
    input  decode_pkg::word_t      rs_value,
    input  decode_pkg::word_t      rt_value,
    decode_ctrl_if.dst             ctrl,
    output decode_pkg::word_t      alu_operand1,
    output decode_pkg::word_t      alu_operand2,
    output logic                   rf_wen,
    output decode_pkg::reg_addr_t  rf_wdest,
    output logic                   mem_load,
    output logic                   mem_store,
    output decode_pkg::alu_op_t    alu_op
);

    decode_pkg::word_t imm_ext;

    always_comb begin
        case (ctrl.imm_kind)
            decode_pkg::IMM_ZERO: imm_ext = {16'd0, ctrl.imm};
            decode_pkg::IMM_SIGN: imm_ext = {{16{ctrl.imm[15]}}, ctrl.imm};
            default:              imm_ext = rt_value;   // register form
        endcase
    end

    // links compute pc + 8 in the ALU
    assign alu_operand1 = ctrl.is_link ? pc :
                          ctrl.uses_sa ? {27'd0, ctrl.sa} : rs_value;
    assign alu_operand2 = ctrl.is_link ? decode_pkg::LINK_OFFSET : imm_ext;

    always_comb begin
        case (ctrl.wdest_kind)
            decode_pkg::WD_RT:  rf_wdest = ctrl.rt;
            decode_pkg::WD_RD:  rf_wdest = ctrl.rd;
            decode_pkg::WD_R31: rf_wdest = decode_pkg::LINK_REG;
            default:            rf_wdest = '0;      // keeps hazard compares clean
        endcase
    end

    assign rf_wen    = (ctrl.wdest_kind != decode_pkg::WD_NONE);
    assign mem_load  = ctrl.is_load;
    assign mem_store = ctrl.is_store;
    assign alu_op    = ctrl.alu_op;

    always_comb begin
        a_alu_onehot: assert final ($onehot0(alu_op))
            else $error("operand_mux: more than one ALU operation decoded");
    end

endmodule

//--- verilog/stall_check.sv
`timescale 1ns/1ps

module stall_check (
    input  logic                  id_valid,
    input  logic                  fetch_valid,
    input  logic                  exe_allowin,
    input  decode_pkg::reg_addr_t exe_wdest,
    input  decode_pkg::reg_addr_t mem_wdest,
    input  decode_pkg::reg_addr_t wb_wdest,
    decode_ctrl_if.dst            ctrl,
    output logic                  id_over
);

    logic rs_wait, rt_wait;

    // r0 never creates a hazard
    assign rs_wait = (ctrl.rs != '0)
                   && (ctrl.rs == exe_wdest || ctrl.rs == mem_wdest || ctrl.rs == wb_wdest);
    assign rt_wait = !ctrl.no_rt && (ctrl.rt != '0)
                   && (ctrl.rt == exe_wdest || ctrl.rt == mem_wdest || ctrl.rt == wb_wdest);

    // a jump or branch waits for its delay slot to be fetched
    assign id_over = id_valid && !rs_wait && !rt_wait && exe_allowin
                   && (!ctrl.is_jbr || fetch_valid);

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  decode_pkg::word_t pc,
    input  decode_pkg::word_t rs_value,
    input  decode_pkg::word_t rt_value,
    input  logic              id_over,
    decode_ctrl_if.dst        ctrl,
    output logic              jbr_taken,
    output decode_pkg::word_t jbr_target
);

    decode_pkg::word_t bd_pc;
    decode_pkg::word_t j_target;
    decode_pkg::word_t br_target;
    logic rs_eq_rt, rs_zero, rs_neg;
    logic br_taken;

    assign bd_pc = pc + 32'd4;                      // delay slot

    assign j_target  = ctrl.is_jr ? rs_value : {bd_pc[31:28], ctrl.target, 2'b00};
    assign br_target = bd_pc + {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_zero  = (rs_value == '0);
    assign rs_neg   = rs_value[31];

    always_comb begin
        case (ctrl.br_cond)
            decode_pkg::BR_EQ:  br_taken = rs_eq_rt;
            decode_pkg::BR_NE:  br_taken = !rs_eq_rt;
            decode_pkg::BR_GEZ: br_taken = !rs_neg;
            decode_pkg::BR_GTZ: br_taken = !rs_neg && !rs_zero;
            decode_pkg::BR_LEZ: br_taken = rs_neg || rs_zero;
            decode_pkg::BR_LTZ: br_taken = rs_neg;
            default:            br_taken = 1'b0;
        endcase
    end

    // only redirect fetch once the stage actually completes
    assign jbr_taken  = (ctrl.is_jump || br_taken) && id_over;
    assign jbr_target = ctrl.is_jump ? j_target : br_target;

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::word_t inst,
    decode_ctrl_if.src        ctrl
);

    logic [decode_pkg::OPC_W-1:0] op;
    logic [decode_pkg::OPC_W-1:0] funct;
    logic special, sa_zero, rs_zero, rt_zero;
    logic i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_lw, i_sw, i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_j, i_jal;
    logic imm_zero, imm_sign, reg_alu, branch;

    //**************************************************************************
    // fields
    assign op          = inst[31:26];
    assign funct       = inst[5:0];
    assign ctrl.rs     = inst[25:21];
    assign ctrl.rt     = inst[20:16];
    assign ctrl.rd     = inst[15:11];
    assign ctrl.sa     = inst[10:6];
    assign ctrl.imm    = inst[15:0];
    assign ctrl.target = inst[25:0];

    assign special = (op == decode_pkg::OP_SPECIAL);
    assign sa_zero = (ctrl.sa == '0);
    assign rs_zero = (ctrl.rs == '0);
    assign rt_zero = (ctrl.rt == '0);

    //**************************************************************************
    // instruction match, anything else falls through as a no-op
    assign i_addu  = special && sa_zero && (funct == decode_pkg::FN_ADDU);
    assign i_subu  = special && sa_zero && (funct == decode_pkg::FN_SUBU);
    assign i_slt   = special && sa_zero && (funct == decode_pkg::FN_SLT);
    assign i_sltu  = special && sa_zero && (funct == decode_pkg::FN_SLTU);
    assign i_and   = special && sa_zero && (funct == decode_pkg::FN_AND);
    assign i_or    = special && sa_zero && (funct == decode_pkg::FN_OR);
    assign i_xor   = special && sa_zero && (funct == decode_pkg::FN_XOR);
    assign i_nor   = special && sa_zero && (funct == decode_pkg::FN_NOR);
    assign i_sll   = special && rs_zero && (funct == decode_pkg::FN_SLL);
    assign i_srl   = special && rs_zero && (funct == decode_pkg::FN_SRL);
    assign i_sra   = special && rs_zero && (funct == decode_pkg::FN_SRA);
    assign i_sllv  = special && sa_zero && (funct == decode_pkg::FN_SLLV);
    assign i_srlv  = special && sa_zero && (funct == decode_pkg::FN_SRLV);
    assign i_srav  = special && sa_zero && (funct == decode_pkg::FN_SRAV);
    assign i_jr    = special && sa_zero && rt_zero && (ctrl.rd == '0)
                   && (funct == decode_pkg::FN_JR);
    assign i_jalr  = special && sa_zero && rt_zero && (funct == decode_pkg::FN_JALR);
    assign i_addiu = (op == decode_pkg::OP_ADDIU);
    assign i_slti  = (op == decode_pkg::OP_SLTI);
    assign i_sltiu = (op == decode_pkg::OP_SLTIU);
    assign i_andi  = (op == decode_pkg::OP_ANDI);
    assign i_ori   = (op == decode_pkg::OP_ORI);
    assign i_xori  = (op == decode_pkg::OP_XORI);
    assign i_lui   = (op == decode_pkg::OP_LUI) && rs_zero;
    assign i_lw    = (op == decode_pkg::OP_LW);
    assign i_sw    = (op == decode_pkg::OP_SW);
    assign i_beq   = (op == decode_pkg::OP_BEQ);
    assign i_bne   = (op == decode_pkg::OP_BNE);
    assign i_bgez  = (op == decode_pkg::OP_REGIMM) && (ctrl.rt == 5'd1);
    assign i_bltz  = (op == decode_pkg::OP_REGIMM) && rt_zero;
    assign i_bgtz  = (op == decode_pkg::OP_BGTZ) && rt_zero;
    assign i_blez  = (op == decode_pkg::OP_BLEZ) && rt_zero;
    assign i_j     = (op == decode_pkg::OP_J);
    assign i_jal   = (op == decode_pkg::OP_JAL);

    //**************************************************************************
    // class reduction
    assign imm_zero = i_andi || i_ori || i_xori || i_lui;
    assign imm_sign = i_addiu || i_slti || i_sltiu || i_lw || i_sw;
    assign reg_alu  = i_addu || i_subu || i_slt || i_sltu || i_and || i_or || i_xor
                    || i_nor || i_sll || i_srl || i_sra || i_sllv || i_srlv || i_srav;
    assign branch   = i_beq || i_bne || i_bgez || i_bgtz || i_blez || i_bltz;

    assign ctrl.alu_op = '{
        op_add:  i_addu || i_addiu || i_lw || i_sw || i_jal || i_jalr,
        op_sub:  i_subu,
        op_slt:  i_slt || i_slti,
        op_sltu: i_sltu || i_sltiu,
        op_and:  i_and || i_andi,
        op_nor:  i_nor,
        op_or:   i_or || i_ori,
        op_xor:  i_xor || i_xori,
        op_sll:  i_sll || i_sllv,
        op_srl:  i_srl || i_srlv,
        op_sra:  i_sra || i_srav,
        op_lui:  i_lui
    };

    assign ctrl.imm_kind   = imm_zero ? decode_pkg::IMM_ZERO :
                             imm_sign ? decode_pkg::IMM_SIGN : decode_pkg::IMM_NONE;
    assign ctrl.wdest_kind = (imm_zero || i_addiu || i_slti || i_sltiu || i_lw) ?
                                 decode_pkg::WD_RT :
                             i_jal ? decode_pkg::WD_R31 :
                             (reg_alu || i_jalr) ? decode_pkg::WD_RD : decode_pkg::WD_NONE;
    assign ctrl.br_cond    = i_beq  ? decode_pkg::BR_EQ  :
                             i_bne  ? decode_pkg::BR_NE  :
                             i_bgez ? decode_pkg::BR_GEZ :
                             i_bgtz ? decode_pkg::BR_GTZ :
                             i_blez ? decode_pkg::BR_LEZ :
                             i_bltz ? decode_pkg::BR_LTZ : decode_pkg::BR_NONE;

    assign ctrl.is_jump  = i_j || i_jal || i_jr || i_jalr;
    assign ctrl.is_jr    = i_jr || i_jalr;
    assign ctrl.is_link  = i_jal || i_jalr;
    assign ctrl.uses_sa  = i_sll || i_srl || i_sra;
    assign ctrl.is_load  = i_lw;
    assign ctrl.is_store = i_sw;
    assign ctrl.is_jbr   = ctrl.is_jump || branch;
    assign ctrl.no_rt    = imm_zero || i_addiu || i_slti || i_sltiu || i_lw
                         || i_bgez || i_bltz || i_bgtz || i_blez || ctrl.is_jump;

endmodule

//--- verilog/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  decode_pkg::word_t fetch_pc,
    input  decode_pkg::word_t fetch_inst,
    input  logic              id_over,
    input  logic              exe_allowin,
    output logic              id_valid,
    output logic              id_allowin,
    output decode_pkg::word_t pc,
    output decode_pkg::word_t inst
);

    // empty, or the current instruction leaves this cycle
    assign id_allowin = !id_valid || (id_over && exe_allowin);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= fetch_valid;                // no fetch means a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && id_allowin) begin
            pc   <= fetch_pc;
            inst <= fetch_inst;
        end
    end

    // a stalled instruction must not change under the decoder
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (id_valid && !id_allowin) |=> ($stable(pc) && $stable(inst))
    ) else $error("if_id_reg: held instruction changed");

endmodule

//--- verilog/decode_ctrl_if.sv
`timescale 1ns/1ps

interface decode_ctrl_if;
    decode_pkg::reg_addr_t              rs;
    decode_pkg::reg_addr_t              rt;
    decode_pkg::reg_addr_t              rd;
    logic [decode_pkg::REG_ADDR_W-1:0]  sa;         // constant shift amount
    logic [decode_pkg::IMM_W-1:0]       imm;        // also the branch offset
    logic [decode_pkg::TGT_W-1:0]       target;
    decode_pkg::alu_op_t                alu_op;
    decode_pkg::imm_kind_t              imm_kind;
    decode_pkg::wdest_kind_t            wdest_kind;
    decode_pkg::br_cond_t               br_cond;
    logic is_jump, is_jr, is_link;
    logic uses_sa;
    logic is_load, is_store;
    logic no_rt;                                    // rt is not read
    logic is_jbr;

    modport src (
        output rs, rt, rd, sa, imm, target, alu_op, imm_kind, wdest_kind, br_cond,
               is_jump, is_jr, is_link, uses_sa, is_load, is_store, no_rt, is_jbr
    );
    modport dst (
        input  rs, rt, rd, sa, imm, target, alu_op, imm_kind, wdest_kind, br_cond,
               is_jump, is_jr, is_link, uses_sa, is_load, is_store, no_rt, is_jbr
    );
endinterface

//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 6;                  // opcode and funct fields
    localparam int IMM_W      = 16;
    localparam int TGT_W      = 26;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one-hot ALU control, add sits in the msb
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_nor;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
    } alu_op_t;

    typedef enum logic [1:0] {IMM_NONE, IMM_ZERO, IMM_SIGN} imm_kind_t;
    typedef enum logic [1:0] {WD_NONE, WD_RT, WD_RD, WD_R31} wdest_kind_t;
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ
    } br_cond_t;

    //**************************************************************************
    // opcodes
    localparam logic [OPC_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [OPC_W-1:0] OP_REGIMM  = 6'b000001;    // bltz/bgez by rt
    localparam logic [OPC_W-1:0] OP_J       = 6'b000010;
    localparam logic [OPC_W-1:0] OP_JAL     = 6'b000011;
    localparam logic [OPC_W-1:0] OP_BEQ     = 6'b000100;
    localparam logic [OPC_W-1:0] OP_BNE     = 6'b000101;
    localparam logic [OPC_W-1:0] OP_BLEZ    = 6'b000110;
    localparam logic [OPC_W-1:0] OP_BGTZ    = 6'b000111;
    localparam logic [OPC_W-1:0] OP_ADDIU   = 6'b001001;
    localparam logic [OPC_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [OPC_W-1:0] OP_SLTIU   = 6'b001011;
    localparam logic [OPC_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [OPC_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [OPC_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [OPC_W-1:0] OP_LUI     = 6'b001111;
    localparam logic [OPC_W-1:0] OP_LW      = 6'b100011;
    localparam logic [OPC_W-1:0] OP_SW      = 6'b101011;

    //**************************************************************************
    // funct codes under OP_SPECIAL
    localparam logic [OPC_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [OPC_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [OPC_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [OPC_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [OPC_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [OPC_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [OPC_W-1:0] FN_JR   = 6'b001000;
    localparam logic [OPC_W-1:0] FN_JALR = 6'b001001;
    localparam logic [OPC_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [OPC_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [OPC_W-1:0] FN_AND  = 6'b100100;
    localparam logic [OPC_W-1:0] FN_OR   = 6'b100101;
    localparam logic [OPC_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [OPC_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [OPC_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [OPC_W-1:0] FN_SLTU = 6'b101011;

    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;      // return past the delay slot

endpackage
